// File: Bender.yml
package:
  name: ibuf

sources:
  - files:
      - hw/ibuf_pkg.sv
      - hw/instr_decoder.sv
      - hw/warp_queue.sv
      - hw/issue_scheduler.sv
      - hw/ibuf_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/ibuf_tb.sv

// File: all.f
+incdir+tb
hw/ibuf_pkg.sv
hw/instr_decoder.sv
hw/warp_queue.sv
hw/issue_scheduler.sv
hw/ibuf_top.sv
tb/ibuf_tb.sv

// File: hw/ibuf_pkg.sv
package ibuf_pkg;

    // Field widths.
    localparam int REG_W    = 5;
    localparam int IMM_W    = 12;
    localparam int PC_W     = 32;
    localparam int EX_W     = 2;
    localparam int OP_W     = 3;              // Carries funct3.
    localparam int OPC_W    = 7;
    localparam int FUNCT7_W = 7;

    // Opcode groups of the reduced ISA.
    localparam logic [OPC_W-1:0] OPC_ALU_R = 7'b0110011;  // Register-register ALU.
    localparam logic [OPC_W-1:0] OPC_ALU_I = 7'b0010011;  // Register-immediate ALU.
    localparam logic [OPC_W-1:0] OPC_LOAD  = 7'b0000011;  // Load, base plus offset.

    // Execution units.
    localparam logic [EX_W-1:0] EX_ALU = 2'd0;
    localparam logic [EX_W-1:0] EX_LSU = 2'd1;

    // One fetched word, seen as either instruction format.
    typedef union packed {
        struct packed {
            logic [FUNCT7_W-1:0] funct7;
            logic [REG_W-1:0]    rs2;
            logic [REG_W-1:0]    rs1;
            logic [OP_W-1:0]     funct3;
            logic [REG_W-1:0]    rd;
            logic [OPC_W-1:0]    opcode;
        } r_fmt;
        struct packed {
            logic [IMM_W-1:0]    imm12;           // Sign is left to the execute stage.
            logic [REG_W-1:0]    rs1;
            logic [OP_W-1:0]     funct3;
            logic [REG_W-1:0]    rd;
            logic [OPC_W-1:0]    opcode;
        } i_fmt;
    } instr_word_t;

endpackage

// File: hw/ibuf_top.sv
module ibuf_top #(
    parameter  int NUM_WARPS  = 4,
    parameter  int IBUF_DEPTH = 4,
    localparam int WID_W      = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          fetch_valid,
    output logic                          fetch_ready,
    input  logic [WID_W-1:0]              fetch_wid,
    input  logic [ibuf_pkg::PC_W-1:0]     fetch_pc,
    input  ibuf_pkg::instr_word_t         fetch_instr,

    input  logic                          freeze,

    output logic                          issue_valid,
    input  logic                          issue_ready,
    output logic [WID_W-1:0]              issue_wid,
    output logic [ibuf_pkg::PC_W-1:0]     issue_pc,
    output logic [ibuf_pkg::EX_W-1:0]     issue_ex,
    output logic [ibuf_pkg::OP_W-1:0]     issue_op,
    output logic [ibuf_pkg::REG_W-1:0]    issue_rd,
    output logic [ibuf_pkg::REG_W-1:0]    issue_rs1,
    output logic [ibuf_pkg::REG_W-1:0]    issue_rs2,
    output logic [ibuf_pkg::IMM_W-1:0]    issue_imm,
    output logic                          issue_use_imm
);

    logic                                       dec_valid;
    logic [WID_W-1:0]                           dec_wid;
    logic [ibuf_pkg::PC_W-1:0]                  dec_pc;
    logic [ibuf_pkg::EX_W-1:0]                  dec_ex;
    logic [ibuf_pkg::OP_W-1:0]                  dec_op;
    logic [ibuf_pkg::REG_W-1:0]                 dec_rd;
    logic [ibuf_pkg::REG_W-1:0]                 dec_rs1;
    logic [ibuf_pkg::REG_W-1:0]                 dec_rs2;
    logic [ibuf_pkg::IMM_W-1:0]                 dec_imm;
    logic                                       dec_use_imm;

    logic [NUM_WARPS-1:0]                       push;
    logic [NUM_WARPS-1:0]                       pop;
    logic [NUM_WARPS-1:0]                       q_full;
    logic [NUM_WARPS-1:0]                       q_not_empty;
    logic [NUM_WARPS-1:0][ibuf_pkg::PC_W-1:0]   head_pc;
    logic [NUM_WARPS-1:0][ibuf_pkg::EX_W-1:0]   head_ex;
    logic [NUM_WARPS-1:0][ibuf_pkg::OP_W-1:0]   head_op;
    logic [NUM_WARPS-1:0][ibuf_pkg::REG_W-1:0]  head_rd;
    logic [NUM_WARPS-1:0][ibuf_pkg::REG_W-1:0]  head_rs1;
    logic [NUM_WARPS-1:0][ibuf_pkg::REG_W-1:0]  head_rs2;
    logic [NUM_WARPS-1:0][ibuf_pkg::IMM_W-1:0]  head_imm;
    logic [NUM_WARPS-1:0]                       head_use_imm;

    instr_decoder #(
        .NUM_WARPS (NUM_WARPS)
    ) i_decoder (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch_wid   (fetch_wid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .q_full      (q_full),
        .push        (push),
        .dec_valid   (dec_valid),
        .dec_wid     (dec_wid),
        .dec_pc      (dec_pc),
        .dec_ex      (dec_ex),
        .dec_op      (dec_op),
        .dec_rd      (dec_rd),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_imm     (dec_imm),
        .dec_use_imm (dec_use_imm)
    );

    for (genvar i = 0; i < NUM_WARPS; i++) begin : g_warp
        warp_queue #(
            .IBUF_DEPTH (IBUF_DEPTH)
        ) i_queue (
            .clk          (clk),
            .reset        (reset),
            .push         (push[i]),
            .pop          (pop[i]),
            .in_pc        (dec_pc),
            .in_ex        (dec_ex),
            .in_op        (dec_op),
            .in_rd        (dec_rd),
            .in_rs1       (dec_rs1),
            .in_rs2       (dec_rs2),
            .in_imm       (dec_imm),
            .in_use_imm   (dec_use_imm),
            .full         (q_full[i]),
            .not_empty    (q_not_empty[i]),
            .head_pc      (head_pc[i]),
            .head_ex      (head_ex[i]),
            .head_op      (head_op[i]),
            .head_rd      (head_rd[i]),
            .head_rs1     (head_rs1[i]),
            .head_rs2     (head_rs2[i]),
            .head_imm     (head_imm[i]),
            .head_use_imm (head_use_imm[i])
        );
    end

    issue_scheduler #(
        .NUM_WARPS (NUM_WARPS)
    ) i_sched (
        .clk           (clk),
        .reset         (reset),
        .freeze        (freeze),
        .not_empty     (q_not_empty),
        .head_pc       (head_pc),
        .head_ex       (head_ex),
        .head_op       (head_op),
        .head_rd       (head_rd),
        .head_rs1      (head_rs1),
        .head_rs2      (head_rs2),
        .head_imm      (head_imm),
        .head_use_imm  (head_use_imm),
        .pop           (pop),
        .issue_valid   (issue_valid),
        .issue_ready   (issue_ready),
        .issue_wid     (issue_wid),
        .issue_pc      (issue_pc),
        .issue_ex      (issue_ex),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_use_imm (issue_use_imm)
    );

endmodule

// File: hw/instr_decoder.sv
module instr_decoder #(
    parameter  int NUM_WARPS = 4,
    localparam int WID_W     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                          clk,
    input  logic                          reset,

    input  logic                          fetch_valid,
    output logic                          fetch_ready,
    input  logic [WID_W-1:0]              fetch_wid,
    input  logic [ibuf_pkg::PC_W-1:0]     fetch_pc,
    input  ibuf_pkg::instr_word_t         fetch_instr,

    input  logic [NUM_WARPS-1:0]          q_full,
    output logic [NUM_WARPS-1:0]          push,

    output logic                          dec_valid,
    output logic [WID_W-1:0]              dec_wid,
    output logic [ibuf_pkg::PC_W-1:0]     dec_pc,
    output logic [ibuf_pkg::EX_W-1:0]     dec_ex,
    output logic [ibuf_pkg::OP_W-1:0]     dec_op,
    output logic [ibuf_pkg::REG_W-1:0]    dec_rd,
    output logic [ibuf_pkg::REG_W-1:0]    dec_rs1,
    output logic [ibuf_pkg::REG_W-1:0]    dec_rs2,
    output logic [ibuf_pkg::IMM_W-1:0]    dec_imm,
    output logic                          dec_use_imm
);

    logic [ibuf_pkg::EX_W-1:0]  ex_d;
    logic [ibuf_pkg::OP_W-1:0]  op_d;
    logic [ibuf_pkg::REG_W-1:0] rd_d;
    logic [ibuf_pkg::REG_W-1:0] rs1_d;
    logic [ibuf_pkg::REG_W-1:0] rs2_d;
    logic [ibuf_pkg::IMM_W-1:0] imm_d;
    logic                       use_imm_d;
    logic                       fetch_fire;
    logic                       drain;

    always_comb begin
        ex_d      = ibuf_pkg::EX_ALU;
        op_d      = fetch_instr.r_fmt.funct3;
        rd_d      = fetch_instr.r_fmt.rd;
        rs1_d     = fetch_instr.i_fmt.rs1;
        rs2_d     = '0;
        imm_d     = '0;
        use_imm_d = 1'b0;
        case (fetch_instr.r_fmt.opcode)
            ibuf_pkg::OPC_ALU_R: begin
                rs2_d = fetch_instr.r_fmt.rs2;
            end
            ibuf_pkg::OPC_ALU_I: begin
                imm_d     = fetch_instr.i_fmt.imm12;
                use_imm_d = 1'b1;
            end
            ibuf_pkg::OPC_LOAD: begin
                ex_d      = ibuf_pkg::EX_LSU;
                imm_d     = fetch_instr.i_fmt.imm12;
                use_imm_d = 1'b1;
            end
            default: begin                    // Unknown opcode becomes a nop.
                op_d  = '0;
                rd_d  = '0;
                rs1_d = '0;
            end
        endcase
    end

    // The held entry leaves as soon as its own queue has room.
    assign drain       = dec_valid && !q_full[dec_wid];
    assign fetch_ready = !dec_valid || drain;
    assign fetch_fire  = fetch_valid && fetch_ready;

    always_comb begin
        push = '0;
        if (dec_valid) begin
            push[dec_wid] = 1'b1;             // One-hot to the addressed warp.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (fetch_fire) begin
            dec_valid <= 1'b1;
        end else if (drain) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            dec_wid     <= fetch_wid;
            dec_pc      <= fetch_pc;
            dec_ex      <= ex_d;
            dec_op      <= op_d;
            dec_rd      <= rd_d;
            dec_rs1     <= rs1_d;
            dec_rs2     <= rs2_d;
            dec_imm     <= imm_d;
            dec_use_imm <= use_imm_d;
        end
    end

endmodule

// File: hw/issue_scheduler.sv
module issue_scheduler #(
    parameter  int NUM_WARPS = 4,
    localparam int WID_W     = (NUM_WARPS > 1) ? $clog2(NUM_WARPS) : 1
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        freeze,

    input  logic [NUM_WARPS-1:0]                        not_empty,
    input  logic [NUM_WARPS-1:0][ibuf_pkg::PC_W-1:0]    head_pc,
    input  logic [NUM_WARPS-1:0][ibuf_pkg::EX_W-1:0]    head_ex,
    input  logic [NUM_WARPS-1:0][ibuf_pkg::OP_W-1:0]    head_op,
    input  logic [NUM_WARPS-1:0][ibuf_pkg::REG_W-1:0]   head_rd,
    input  logic [NUM_WARPS-1:0][ibuf_pkg::REG_W-1:0]   head_rs1,
    input  logic [NUM_WARPS-1:0][ibuf_pkg::REG_W-1:0]   head_rs2,
    input  logic [NUM_WARPS-1:0][ibuf_pkg::IMM_W-1:0]   head_imm,
    input  logic [NUM_WARPS-1:0]                        head_use_imm,
    output logic [NUM_WARPS-1:0]                        pop,

    output logic                                        issue_valid,
    input  logic                                        issue_ready,
    output logic [WID_W-1:0]                            issue_wid,
    output logic [ibuf_pkg::PC_W-1:0]                   issue_pc,
    output logic [ibuf_pkg::EX_W-1:0]                   issue_ex,
    output logic [ibuf_pkg::OP_W-1:0]                   issue_op,
    output logic [ibuf_pkg::REG_W-1:0]                  issue_rd,
    output logic [ibuf_pkg::REG_W-1:0]                  issue_rs1,
    output logic [ibuf_pkg::REG_W-1:0]                  issue_rs2,
    output logic [ibuf_pkg::IMM_W-1:0]                  issue_imm,
    output logic                                        issue_use_imm
);

    logic [WID_W-1:0] last_wid;
    logic [WID_W-1:0] rr_wid;
    logic             rr_found;
    logic             hold;
    logic [WID_W-1:0] sel_wid;
    logic             sel_valid;
    logic             load;

    // First non-empty warp after last_wid, wrapping back to last_wid itself.
    always_comb begin
        int idx;
        rr_found = 1'b0;
        rr_wid   = last_wid;
        for (int k = 1; k <= NUM_WARPS; k++) begin
            idx = (int'(last_wid) + k) % NUM_WARPS;
            if (!rr_found && not_empty[idx]) begin
                rr_found = 1'b1;
                rr_wid   = WID_W'(idx);
            end
        end
    end

    assign hold      = freeze && not_empty[last_wid];  // Stay on the current warp.
    assign sel_wid   = hold ? last_wid : rr_wid;
    assign sel_valid = hold || rr_found;
    assign load      = (!issue_valid || issue_ready) && sel_valid;

    always_comb begin
        pop = '0;
        if (load) begin
            pop[sel_wid] = 1'b1;
        end
    end

    // The issued warp is always the one loaded last.
    assign issue_wid = last_wid;

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= 1'b0;
            last_wid    <= WID_W'(NUM_WARPS - 1);      // Warp 0 goes first.
        end else if (load) begin
            issue_valid <= 1'b1;
            last_wid    <= sel_wid;
        end else if (issue_ready) begin
            issue_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            issue_pc      <= head_pc[sel_wid];
            issue_ex      <= head_ex[sel_wid];
            issue_op      <= head_op[sel_wid];
            issue_rd      <= head_rd[sel_wid];
            issue_rs1     <= head_rs1[sel_wid];
            issue_rs2     <= head_rs2[sel_wid];
            issue_imm     <= head_imm[sel_wid];
            issue_use_imm <= head_use_imm[sel_wid];
        end
    end

endmodule

// File: hw/warp_queue.sv
module warp_queue #(
    parameter  int IBUF_DEPTH = 4,
    localparam int PTR_W      = (IBUF_DEPTH > 1) ? $clog2(IBUF_DEPTH) : 1,
    localparam int CNT_W      = $clog2(IBUF_DEPTH + 1)
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          push,
    input  logic                          pop,

    input  logic [ibuf_pkg::PC_W-1:0]     in_pc,
    input  logic [ibuf_pkg::EX_W-1:0]     in_ex,
    input  logic [ibuf_pkg::OP_W-1:0]     in_op,
    input  logic [ibuf_pkg::REG_W-1:0]    in_rd,
    input  logic [ibuf_pkg::REG_W-1:0]    in_rs1,
    input  logic [ibuf_pkg::REG_W-1:0]    in_rs2,
    input  logic [ibuf_pkg::IMM_W-1:0]    in_imm,
    input  logic                          in_use_imm,

    output logic                          full,
    output logic                          not_empty,

    output logic [ibuf_pkg::PC_W-1:0]     head_pc,
    output logic [ibuf_pkg::EX_W-1:0]     head_ex,
    output logic [ibuf_pkg::OP_W-1:0]     head_op,
    output logic [ibuf_pkg::REG_W-1:0]    head_rd,
    output logic [ibuf_pkg::REG_W-1:0]    head_rs1,
    output logic [ibuf_pkg::REG_W-1:0]    head_rs2,
    output logic [ibuf_pkg::IMM_W-1:0]    head_imm,
    output logic                          head_use_imm
);

    localparam int ENTRY_W = ibuf_pkg::PC_W + ibuf_pkg::EX_W + ibuf_pkg::OP_W
                           + 3 * ibuf_pkg::REG_W + ibuf_pkg::IMM_W + 1;

    logic [ENTRY_W-1:0] mem [IBUF_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               wr_en;
    logic               rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && not_empty;

    assign {head_pc, head_ex, head_op, head_rd, head_rs1, head_rs2, head_imm,
            head_use_imm} = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= {in_pc, in_ex, in_op, in_rd, in_rs1, in_rs2, in_imm, in_use_imm};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            full      <= 1'b0;
            not_empty <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(IBUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(IBUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count     <= count + 1'b1;
                full      <= (count == CNT_W'(IBUF_DEPTH - 1));
                not_empty <= 1'b1;
            end else if (rd_en && !wr_en) begin
                count     <= count - 1'b1;
                full      <= 1'b0;
                not_empty <= (count != CNT_W'(1));
            end
        end
    end

endmodule

// File: tb/ibuf_model.svh
`ifndef IBUF_MODEL_SVH
`define IBUF_MODEL_SVH

localparam int ENTRY_W = ibuf_pkg::PC_W + ibuf_pkg::EX_W + ibuf_pkg::OP_W
                       + 3 * ibuf_pkg::REG_W + ibuf_pkg::IMM_W + 1;

logic [ENTRY_W-1:0] exp_q [NUM_WARPS][$];      // Oldest first, one queue per warp.

function automatic int expected_total();
    int total;
    total = 0;
    for (int w = 0; w < NUM_WARPS; w++) begin
        total += exp_q[w].size();
    end
    return total;
endfunction

function automatic ibuf_pkg::instr_word_t random_word();
    ibuf_pkg::instr_word_t w;
    int                    pick;
    w    = $urandom;
    pick = $urandom_range(0, 9);
    if (pick < 3) begin
        w.r_fmt.opcode = ibuf_pkg::OPC_ALU_R;
    end else if (pick < 6) begin
        w.i_fmt.opcode = ibuf_pkg::OPC_ALU_I;
    end else if (pick < 9) begin
        w.i_fmt.opcode = ibuf_pkg::OPC_LOAD;
    end else begin
        do begin
            w.r_fmt.opcode = 7'($urandom);  // Anything outside the three groups.
        end while (w.r_fmt.opcode inside {ibuf_pkg::OPC_ALU_R, ibuf_pkg::OPC_ALU_I,
                                          ibuf_pkg::OPC_LOAD});
    end
    return w;
endfunction

// Fields packed as pc, ex, op, rd, rs1, rs2, imm, use_imm.
function automatic logic [ENTRY_W-1:0] decode_expected(input logic [31:0] pc,
                                                       input ibuf_pkg::instr_word_t w);
    if (w.r_fmt.opcode == ibuf_pkg::OPC_ALU_R) begin
        return {pc, ibuf_pkg::EX_ALU, w.r_fmt.funct3, w.r_fmt.rd, w.r_fmt.rs1,
                w.r_fmt.rs2, 12'd0, 1'b0};
    end else if (w.i_fmt.opcode == ibuf_pkg::OPC_ALU_I) begin
        return {pc, ibuf_pkg::EX_ALU, w.i_fmt.funct3, w.i_fmt.rd, w.i_fmt.rs1,
                5'd0, w.i_fmt.imm12, 1'b1};
    end else if (w.i_fmt.opcode == ibuf_pkg::OPC_LOAD) begin
        return {pc, ibuf_pkg::EX_LSU, w.i_fmt.funct3, w.i_fmt.rd, w.i_fmt.rs1,
                5'd0, w.i_fmt.imm12, 1'b1};
    end
    return {pc, ibuf_pkg::EX_ALU, 3'd0, 5'd0, 5'd0, 5'd0, 12'd0, 1'b0};  // Nop.
endfunction

// First warp with work strictly after last, wrapping round to last itself.
function automatic int next_rr(input int last, input int cnt[NUM_WARPS]);
    for (int k = 1; k <= NUM_WARPS; k++) begin
        if (cnt[(last + k) % NUM_WARPS] > 0) begin
            return (last + k) % NUM_WARPS;
        end
    end
    return -1;
endfunction

`endif

// File: tb/ibuf_tb.sv
module ibuf_tb;

    localparam int NUM_WARPS  = 4;
    localparam int IBUF_DEPTH = 4;
    localparam int WID_W      = 2;
    localparam int TIMEOUT    = 2000;

    logic                          clk;
    logic                          reset;
    logic                          fetch_valid;
    logic                          fetch_ready;
    logic [WID_W-1:0]              fetch_wid;
    logic [31:0]                   fetch_pc;
    ibuf_pkg::instr_word_t         fetch_instr;
    logic                          freeze;
    logic                          issue_valid;
    logic                          issue_ready;
    logic [WID_W-1:0]              issue_wid;
    logic [31:0]                   issue_pc;
    logic [ibuf_pkg::EX_W-1:0]     issue_ex;
    logic [ibuf_pkg::OP_W-1:0]     issue_op;
    logic [ibuf_pkg::REG_W-1:0]    issue_rd;
    logic [ibuf_pkg::REG_W-1:0]    issue_rs1;
    logic [ibuf_pkg::REG_W-1:0]    issue_rs2;
    logic [ibuf_pkg::IMM_W-1:0]    issue_imm;
    logic                          issue_use_imm;

    string                     test_name;
    bit                        random_ready;
    bit                        stalled;
    logic [WID_W-1:0]          held_wid;
    logic [ibuf_pkg::EX_W-1:0] held_ex;
    logic [31:0]               held_pc;
    logic [30:0]               held_rest;
    logic [31:0]               next_pc;
    int                        issue_log[$];         // Warp ids in issue order.

    `include "ibuf_model.svh"

    ibuf_top i_ibuf_top (
        .clk(clk), .reset(reset), .fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
        .fetch_wid(fetch_wid), .fetch_pc(fetch_pc), .fetch_instr(fetch_instr),
        .freeze(freeze), .issue_valid(issue_valid), .issue_ready(issue_ready),
        .issue_wid(issue_wid), .issue_pc(issue_pc), .issue_ex(issue_ex),
        .issue_op(issue_op), .issue_rd(issue_rd), .issue_rs1(issue_rs1),
        .issue_rs2(issue_rs2), .issue_imm(issue_imm), .issue_use_imm(issue_use_imm)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        #1;
        if (random_ready) begin
            issue_ready = 1'($urandom_range(0, 1));
        end
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_field(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            fail_run($sformatf("[FAIL] %s %s expected %h actual %h", test_name, what, exp, act));
        end
    endtask

    task automatic check_wid(input string what, input logic [WID_W-1:0] exp,
                             input logic [WID_W-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("[FAIL] %s %s expected %0d actual %0d", test_name, what, exp, act));
        end
    endtask

    task automatic check_ex(input string what, input logic [ibuf_pkg::EX_W-1:0] exp,
                            input logic [ibuf_pkg::EX_W-1:0] act);
        if (act !== exp) begin
            fail_run($sformatf("[FAIL] %s %s expected %0d actual %0d", test_name, what, exp, act));
        end
    endtask

    task automatic check_issue();
        logic [31:0]                e_pc;
        logic [ibuf_pkg::EX_W-1:0]  e_ex;
        logic [ibuf_pkg::OP_W-1:0]  e_op;
        logic [ibuf_pkg::REG_W-1:0] e_rd;
        logic [ibuf_pkg::REG_W-1:0] e_rs1;
        logic [ibuf_pkg::REG_W-1:0] e_rs2;
        logic [ibuf_pkg::IMM_W-1:0] e_imm;
        logic                       e_use_imm;
        if (exp_q[issue_wid].size() == 0) begin
            fail_run($sformatf("%s: warp %0d issued an instruction that was never fetched",
                               test_name, issue_wid));
        end
        {e_pc, e_ex, e_op, e_rd, e_rs1, e_rs2, e_imm, e_use_imm} = exp_q[issue_wid].pop_front();
        check_field("pc", e_pc, issue_pc);
        check_ex("ex", e_ex, issue_ex);
        check_field("op", e_op, issue_op);
        check_field("rd", e_rd, issue_rd);
        check_field("rs1", e_rs1, issue_rs1);
        check_field("rs2", e_rs2, issue_rs2);
        check_field("imm", e_imm, issue_imm);
        check_field("use_imm", e_use_imm, issue_use_imm);
        issue_log.push_back(int'(issue_wid));
    endtask

    // Samples at the falling edge, half a cycle away from any change.
    always @(negedge clk) begin
        if (reset) begin
            check_field("issue_valid in reset", 32'd0, issue_valid);
            check_field("fetch_ready in reset", 32'd1, fetch_ready);
        end else begin
            if (fetch_valid && fetch_ready) begin
                exp_q[fetch_wid].push_back(decode_expected(fetch_pc, fetch_instr));
            end
            if (issue_valid && stalled) begin
                check_wid("stalled wid", held_wid, issue_wid);
                check_ex("stalled ex", held_ex, issue_ex);
                check_field("stalled pc", held_pc, issue_pc);
                check_field("stalled fields", held_rest, {issue_op, issue_rd, issue_rs1,
                            issue_rs2, issue_imm, issue_use_imm});
            end
            if (issue_valid && issue_ready) begin
                check_issue();
            end
            stalled   = issue_valid && !issue_ready;
            held_wid  = issue_wid;
            held_ex   = issue_ex;
            held_pc   = issue_pc;
            held_rest = {issue_op, issue_rd, issue_rs1, issue_rs2, issue_imm, issue_use_imm};
        end
    end

    task automatic load_fetch(input int wid);
        fetch_wid   = WID_W'(wid);
        fetch_pc    = next_pc;
        fetch_instr = random_word();
        next_pc     = next_pc + 32'd4;
    endtask

    task automatic fetch_one(input int wid);
        int waited;
        waited = 0;
        load_fetch(wid);
        fetch_valid = 1'b1;
        @(negedge clk);
        while (!fetch_ready) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("%s: timed out waiting for fetch_ready", test_name));
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (expected_total() != 0 || issue_valid) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("%s: timed out waiting for the buffer to drain", test_name));
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_issues(input int count);
        int waited;
        waited = 0;
        while (issue_log.size() < count) begin
            waited++;
            if (waited > TIMEOUT) begin
                fail_run($sformatf("%s: timed out waiting for %0d issues", test_name, count));
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic decode_order_test();
        test_name    = "decode_order";
        random_ready = 1'b1;
        for (int n = 0; n < 200; n++) begin
            fetch_one($urandom_range(0, NUM_WARPS - 1));
            if ($urandom_range(0, 3) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        wait_drained();
        random_ready = 1'b0;
        issue_ready  = 1'b0;
    endtask

    task automatic round_robin_test();
        int cnt[NUM_WARPS];
        int expect_wid[$];
        int last;
        int total;
        test_name = "round_robin";
        for (int w = 0; w < NUM_WARPS; w++) begin
            cnt[w] = (w == 1) ? 0 : $urandom_range(1, IBUF_DEPTH);  // Warp 1 stays empty.
            repeat (cnt[w]) fetch_one(w);
        end
        repeat (2) @(posedge clk);
        #1;
        for (int w = 0; w < NUM_WARPS; w++) begin
            cnt[w] = exp_q[w].size();
        end
        total = expected_total();
        last  = 0;                                   // Warp 0 was fetched first.
        expect_wid.push_back(last);
        cnt[last]--;
        while (expect_wid.size() < total) begin
            last = next_rr(last, cnt);
            expect_wid.push_back(last);
            cnt[last]--;
        end
        issue_log.delete();
        issue_ready = 1'b1;
        wait_issues(total);
        for (int i = 0; i < total; i++) begin
            check_wid($sformatf("issue %0d wid", i), WID_W'(expect_wid[i]), WID_W'(issue_log[i]));
        end
        wait_drained();
        issue_ready = 1'b0;
    endtask

    task automatic freeze_test();
        int first;
        int hold_cnt;
        int total;
        test_name = "freeze";
        for (int w = 0; w < NUM_WARPS; w++) begin
            repeat ($urandom_range(2, 3)) fetch_one(w);
        end
        repeat (2) @(posedge clk);
        #1;
        freeze      = 1'b1;
        first       = 0;                             // Warp 0 sits in the issue register.
        hold_cnt    = exp_q[first].size();
        total       = expected_total();
        issue_log.delete();
        issue_ready = 1'b1;
        wait_issues(total);
        for (int i = 0; i < hold_cnt; i++) begin
            check_wid($sformatf("frozen issue %0d wid", i), WID_W'(first), WID_W'(issue_log[i]));
        end
        wait_drained();
        freeze      = 1'b0;
        issue_ready = 1'b0;
    endtask

    task automatic capacity_test();
        int   wid;
        int   transfers;
        int   stalls;
        logic accepted;
        test_name = "capacity";
        wid       = $urandom_range(0, NUM_WARPS - 1);
        transfers = 0;
        stalls    = 0;
        load_fetch(wid);
        fetch_valid = 1'b1;
        while (stalls < 8) begin
            @(negedge clk);
            accepted = fetch_ready;
            @(posedge clk);
            #1;
            if (accepted) begin
                transfers++;
                stalls = 0;
                load_fetch(wid);                     // Fresh word only after a transfer.
            end else begin
                stalls++;
            end
            if (transfers > 4 * IBUF_DEPTH) begin
                fail_run("capacity: fetch_ready never fell with the issue link stalled");
            end
        end
        fetch_valid = 1'b0;
        check_field("transfers before stall", 32'(IBUF_DEPTH + 2), 32'(transfers));
        issue_ready = 1'b1;
        wait_drained();
        issue_ready = 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        fetch_valid  = 1'b0;
        fetch_wid    = '0;
        fetch_pc     = '0;
        fetch_instr  = '0;
        freeze       = 1'b0;
        issue_ready  = 1'b0;
        random_ready = 1'b0;
        stalled      = 1'b0;
        next_pc      = 32'h0000_1000;
        test_name    = "reset";
        void'($urandom(32'h57a6_3607));
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        check_field("issue_valid after reset", 32'd0, issue_valid);
        check_field("fetch_ready after reset", 32'd1, fetch_ready);
        @(posedge clk);
        #1;
        decode_order_test();
        round_robin_test();
        freeze_test();
        capacity_test();
        $display("Regression passed");
        $finish;
    end

endmodule
